// File: blur_3x3.sv
`timescale 1ns/1ps
`include "blur_defs.svh"

module blur_3x3 import blur_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      win_req,
  input  row_t      win_top,
  input  row_t      win_mid,
  input  row_t      win_bot,
  output logic      win_ack,
  output logic      blur_we,
  output row_addr_t blur_addr,
  output row_t      blur_din,
  output logic      done
);

  // rows padded with a zero pixel on each side
  logic [(`IMG_W+2)*`PIX_W-1:0] ext_top;
  logic [(`IMG_W+2)*`PIX_W-1:0] ext_mid;
  logic [(`IMG_W+2)*`PIX_W-1:0] ext_bot;

  // vertical 1 2 1 sums per padded column
  logic [`PIX_W+1:0] vsum [`IMG_W+2];
  row_t              filt_row;
  row_addr_t         out_row;
  logic              take;

  assign ext_top = {pixel_t'(0), win_top, pixel_t'(0)};
  assign ext_mid = {pixel_t'(0), win_mid, pixel_t'(0)};
  assign ext_bot = {pixel_t'(0), win_bot, pixel_t'(0)};

  always_comb begin
    for (int e = 0; e < `IMG_W + 2; e++) begin
      vsum[e] = {2'b00, ext_top[e*`PIX_W +: `PIX_W]}
              + {1'b0, ext_mid[e*`PIX_W +: `PIX_W], 1'b0}
              + {2'b00, ext_bot[e*`PIX_W +: `PIX_W]};
    end
  end

  // horizontal 1 2 1 pass, then divide by 16 with truncation
  always_comb begin
    logic [`PIX_W+`KERNEL_SHIFT-1:0] hsum;
    for (int c = 0; c < `IMG_W; c++) begin
      hsum = {2'b00, vsum[c]} + {1'b0, vsum[c+1], 1'b0} + {2'b00, vsum[c+2]};
      filt_row[c*`PIX_W +: `PIX_W] = hsum[`PIX_W+`KERNEL_SHIFT-1:`KERNEL_SHIFT];
    end
  end

  // new window not yet acknowledged
  assign take      = win_req && !win_ack;
  assign blur_addr = out_row;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_ack <= 1'b0;
      blur_we <= 1'b0;
      done    <= 1'b0;
      out_row <= '0;
    end else begin
      blur_we <= take;
      done    <= take && (out_row == `IMG_H - 1);
      if (take) begin
        win_ack <= 1'b1;
      end else if (!win_req) begin
        win_ack <= 1'b0;
      end
      // advance after each write, wrap for the next frame
      if (blur_we) begin
        out_row <= (out_row == `IMG_H - 1) ? '0 : out_row + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      blur_din <= filt_row;
    end
  end

endmodule

// File: blur_defs.svh
`ifndef BLUR_DEFS_SVH
`define BLUR_DEFS_SVH

// image geometry, one row per memory word
`define IMG_W 16
`define IMG_H 8

// grayscale depth
`define PIX_W 8

// enough to address IMG_H rows
`define ROW_AW 3

// weights 1 2 1 / 2 4 2 / 1 2 1 sum to 16
`define KERNEL_SHIFT 4

`endif

// File: blur_pkg.sv
`include "blur_defs.svh"

package blur_pkg;

  // one grayscale pixel
  typedef logic [`PIX_W-1:0] pixel_t;

  // full image row, pixel 0 in the low bits
  typedef logic [`IMG_W*`PIX_W-1:0] row_t;

  // row index into image and blur memories
  typedef logic [`ROW_AW-1:0] row_addr_t;

  // row fetcher states
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_READ,
    FETCH_PUSH,
    FETCH_WAIT
  } fetch_state_t;

endpackage

// File: blur_top.sv
`timescale 1ns/1ps

module blur_top import blur_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  output logic      done,
  output logic      img_en,
  output row_addr_t img_addr,
  input  row_t      img_data,
  output logic      blur_we,
  output row_addr_t blur_addr,
  output row_t      blur_din
);

  // fetcher to line buffer
  logic push_req;
  logic push_first;
  logic push_ack;
  row_t push_row;

  // line buffer to kernel stage
  logic win_req;
  logic win_ack;
  row_t win_top;
  row_t win_mid;
  row_t win_bot;

  row_fetch fetch_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .img_en     (img_en),
    .img_addr   (img_addr),
    .img_data   (img_data),
    .push_req   (push_req),
    .push_first (push_first),
    .push_row   (push_row),
    .push_ack   (push_ack)
  );

  line_buffer lbuf_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_req   (push_req),
    .push_first (push_first),
    .push_row   (push_row),
    .push_ack   (push_ack),
    .win_req    (win_req),
    .win_top    (win_top),
    .win_mid    (win_mid),
    .win_bot    (win_bot),
    .win_ack    (win_ack)
  );

  blur_3x3 kernel_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .win_req   (win_req),
    .win_top   (win_top),
    .win_mid   (win_mid),
    .win_bot   (win_bot),
    .win_ack   (win_ack),
    .blur_we   (blur_we),
    .blur_addr (blur_addr),
    .blur_din  (blur_din),
    .done      (done)
  );

endmodule

// File: compile.f
+incdir+.
blur_pkg.sv
row_fetch.sv
line_buffer.sv
blur_3x3.sv
blur_top.sv
tb_blur_top.sv

// File: line_buffer.sv
`timescale 1ns/1ps

module line_buffer import blur_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic push_req,
  input  logic push_first,
  input  row_t push_row,
  output logic push_ack,
  output logic win_req,
  output row_t win_top,
  output row_t win_mid,
  output row_t win_bot,
  input  logic win_ack
);

  // rows held since push_first, saturates at three
  logic [1:0] fill;
  logic [1:0] fill_next;
  logic       accept;

  // hold off new rows while a window is still being consumed
  assign accept = push_req && !push_ack && !win_req && !win_ack;

  always_comb begin
    if (push_first) begin
      fill_next = 2'd1;
    end else if (fill == 2'd3) begin
      fill_next = 2'd3;
    end else begin
      fill_next = fill + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill     <= 2'd0;
      push_ack <= 1'b0;
      win_req  <= 1'b0;
    end else begin
      if (accept) begin
        fill     <= fill_next;
        push_ack <= 1'b1;
        // offer a window once three rows are in
        win_req  <= (fill_next == 2'd3);
      end else begin
        if (!push_req) begin
          push_ack <= 1'b0;
        end
        if (win_req && win_ack) begin
          win_req <= 1'b0;
        end
      end
    end
  end

  // newest row enters at the bottom
  always_ff @(posedge clk) begin
    if (accept) begin
      win_top <= win_mid;
      win_mid <= win_bot;
      win_bot <= push_row;
    end
  end

endmodule

// File: row_fetch.sv
`timescale 1ns/1ps
`include "blur_defs.svh"

module row_fetch import blur_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  output logic      img_en,
  output row_addr_t img_addr,
  input  row_t      img_data,
  output logic      push_req,
  output logic      push_first,
  output row_t      push_row,
  input  logic      push_ack
);

  fetch_state_t state;

  // push counter, 0 .. IMG_H+1 per frame
  logic [`ROW_AW:0] cnt;
  logic             last;
  logic             border;

  // first and last push are the zero rows above and below the image
  assign last   = (cnt == `IMG_H + 1);
  assign border = (cnt == '0) || last;

  // image row is one behind the push count
  assign img_en   = (state == FETCH_READ) && !border;
  assign img_addr = row_addr_t'(cnt - 1'b1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= FETCH_IDLE;
      cnt        <= '0;
      push_req   <= 1'b0;
      push_first <= 1'b0;
    end else begin
      case (state)
        FETCH_IDLE: begin
          if (start) begin
            cnt   <= '0;
            state <= FETCH_READ;
          end
        end
        FETCH_READ: begin
          state <= FETCH_PUSH;
        end
        FETCH_PUSH: begin
          // memory data is valid now, row register loads below
          push_req   <= 1'b1;
          push_first <= (cnt == '0);
          state      <= FETCH_WAIT;
        end
        FETCH_WAIT: begin
          if (push_req && push_ack) begin
            push_req <= 1'b0;
          end else if (!push_req && !push_ack) begin
            // handshake closed
            if (last) begin
              state <= FETCH_IDLE;
            end else begin
              cnt   <= cnt + 1'b1;
              state <= FETCH_READ;
            end
          end
        end
        default: begin
          state <= FETCH_IDLE;
        end
      endcase
    end
  end

  // row held stable for the whole push handshake
  always_ff @(posedge clk) begin
    if (state == FETCH_PUSH) begin
      push_row <= border ? '0 : img_data;
    end
  end

endmodule

// File: tb_blur_model.svh
`ifndef TB_BLUR_MODEL_SVH
`define TB_BLUR_MODEL_SVH

// image patterns used by the test table
typedef enum logic [2:0] {
  PAT_ZERO,
  PAT_CONST,
  PAT_IMPULSE,
  PAT_RAMP,
  PAT_RANDOM
} pattern_t;

// fibonacci lfsr with taps 16 14 13 11
logic [15:0] lfsr_state;

function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
  lfsr_state = {lfsr_state[14:0], fb};
  return fb;
endfunction

function automatic pixel_t pattern_pixel(input pattern_t pat, input int r, input int c);
  pixel_t p;
  p = '0;
  case (pat)
    PAT_CONST:   p = pixel_t'(16);
    PAT_IMPULSE: p = (r == 3 && c == 5) ? pixel_t'(160) : pixel_t'(0);
    PAT_RAMP:    p = pixel_t'(r * 16 + c);
    PAT_RANDOM: begin
      // one lfsr step per pixel bit
      for (int b = 0; b < `PIX_W; b++) begin
        p = {p[`PIX_W-2:0], lfsr_bit()};
      end
    end
    default:     p = '0;
  endcase
  return p;
endfunction

// centre tap weighs 2, side taps weigh 1, in both directions
function automatic int kernel_weight(input int d);
  return (d == 0) ? 2 : 1;
endfunction

// reads img_mem of the including testbench, zero outside the image
function automatic int image_pixel(input int r, input int c);
  if (r < 0 || r >= `IMG_H || c < 0 || c >= `IMG_W) begin
    return 0;
  end
  return int'(img_mem[r][c*`PIX_W +: `PIX_W]);
endfunction

function automatic row_t expected_row(input int r);
  row_t row;
  int   sum;
  row = '0;
  for (int c = 0; c < `IMG_W; c++) begin
    sum = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        sum += kernel_weight(dr) * kernel_weight(dc) * image_pixel(r + dr, c + dc);
      end
    end
    row[c*`PIX_W +: `PIX_W] = pixel_t'(sum >> `KERNEL_SHIFT);
  end
  return row;
endfunction

`endif

// File: tb_blur_top.sv
`timescale 1ns/1ps
`include "blur_defs.svh"

module tb_blur_top import blur_pkg::*; ();

  logic      clk = 1'b0;
  logic      rst_n;
  logic      start;
  logic      done;
  logic      img_en;
  row_addr_t img_addr;
  row_t      img_data;
  logic      blur_we;
  row_addr_t blur_addr;
  row_t      blur_din;

  // image source and captured blur output
  row_t      img_mem [`IMG_H];
  row_t      blur_mem [`IMG_H];
  row_addr_t wr_addr_log [`IMG_H];
  row_addr_t rd_addr_log [`IMG_H];
  int        wr_count;
  int        rd_count;
  int        done_count;
  int        errors;
  logic      rd_pending;
  row_addr_t rd_addr;

  `include "tb_blur_model.svh"

  typedef struct packed {
    pattern_t     pat;
    logic [127:0] name;
    logic [3:0]   spot_r;
    logic [3:0]   spot_c;
    pixel_t       spot_val;
    logic         spot_en;
  } test_t;

  localparam int NUM_TESTS      = 7;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (`IMG_H + 2) * 12;

  // corner of constant 16 is 9, impulse centre is 160*4/16, ramp interior keeps its value
  test_t tests [NUM_TESTS] = '{
    '{PAT_ZERO,    "all zero",      4'd4, 4'd4, 8'd0,  1'b1},
    '{PAT_CONST,   "constant 16",   4'd0, 4'd0, 8'd9,  1'b1},
    '{PAT_IMPULSE, "impulse",       4'd3, 4'd5, 8'd40, 1'b1},
    '{PAT_RAMP,    "ramp",          4'd3, 4'd5, 8'd53, 1'b1},
    '{PAT_RANDOM,  "lfsr random",   4'd0, 4'd0, 8'd0,  1'b0},
    '{PAT_ZERO,    "zero again",    4'd0, 4'd0, 8'd0,  1'b1},
    '{PAT_IMPULSE, "impulse again", 4'd2, 4'd4, 8'd10, 1'b1}
  };

  blur_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .done      (done),
    .img_en    (img_en),
    .img_addr  (img_addr),
    .img_data  (img_data),
    .blur_we   (blur_we),
    .blur_addr (blur_addr),
    .blur_din  (blur_din)
  );

  always #2 clk = ~clk;

  // image memory answers img_en one cycle later
  always @(negedge clk) begin
    if (rd_pending) begin
      img_data <= img_mem[rd_addr];
    end
    rd_pending <= img_en;
    rd_addr    <= img_addr;
    if (rst_n && img_en) begin
      if (rd_count < `IMG_H) begin
        rd_addr_log[rd_count] = img_addr;
      end
      rd_count++;
    end
  end

  always @(negedge clk) begin
    if (rst_n && blur_we) begin
      if (wr_count < `IMG_H) begin
        wr_addr_log[wr_count] = blur_addr;
      end
      blur_mem[blur_addr] = blur_din;
      wr_count++;
    end
    if (rst_n && done) begin
      done_count++;
    end
  end

  task automatic check_row(input string name, input row_t got, input row_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input row_addr_t got, input row_addr_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic fill_image(input pattern_t pat);
    for (int r = 0; r < `IMG_H; r++) begin
      for (int c = 0; c < `IMG_W; c++) begin
        img_mem[r][c*`PIX_W +: `PIX_W] = pattern_pixel(pat, r, c);
      end
    end
  endtask

  task automatic run_frame();
    // start is only seen once the fetcher is back in idle
    @(negedge clk);
    while (dut_i.fetch_i.state != FETCH_IDLE) begin
      @(negedge clk);
    end
    for (int r = 0; r < `IMG_H; r++) begin
      blur_mem[r] = 'x;
    end
    wr_count   = 0;
    rd_count   = 0;
    done_count = 0;
    start      = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (done !== 1'b1) begin
      @(negedge clk);
    end
    // last write is captured on this same falling edge
    @(posedge clk);
  endtask

  task automatic check_frame(input int t);
    int r;
    int c;
    for (int i = 0; i < `IMG_H; i++) begin
      check_row($sformatf("blur_din row %0d", i), blur_mem[i], expected_row(i));
    end
    for (int i = 0; i < wr_count && i < `IMG_H; i++) begin
      check_addr($sformatf("blur_addr write %0d", i), wr_addr_log[i], row_addr_t'(i));
    end
    check_count("write count", wr_count, `IMG_H);
    check_count("done pulses", done_count, 1);
    // border rows are zero-filled without a read
    check_count("img_en reads", rd_count, `IMG_H);
    for (int i = 0; i < rd_count && i < `IMG_H; i++) begin
      check_addr($sformatf("img_addr read %0d", i), rd_addr_log[i], row_addr_t'(i));
    end
    if (tests[t].spot_en) begin
      r = tests[t].spot_r;
      c = tests[t].spot_c;
      check_pixel($sformatf("blur_din pixel %0d,%0d", r, c),
                  blur_mem[r][c*`PIX_W +: `PIX_W], tests[t].spot_val);
    end
  endtask

  initial begin
    int test_errors;
    int passed;
    rst_n      = 1'b0;
    start      = 1'b0;
    img_data   = '0;
    rd_pending = 1'b0;
    rd_addr    = '0;
    wr_count   = 0;
    rd_count   = 0;
    done_count = 0;
    errors     = 0;
    passed     = 0;
    lfsr_state = 16'd42;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // each frame starts as soon as the previous one is done
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_errors = errors;
      fill_image(tests[t].pat);
      run_frame();
      check_frame(t);
      test_errors = errors - test_errors;
      if (test_errors == 0) begin
        passed++;
        $display("test %0d %0s: ok", t, tests[t].name);
      end else begin
        $display("test %0d %0s: %0d errors", t, tests[t].name, test_errors);
      end
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             NUM_TESTS, passed, NUM_TESTS - passed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    int           cycles;
    fetch_state_t st;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    st = dut_i.fetch_i.state;
    $display("timeout after %0d cycles without finishing, fetcher in %s", cycles, st.name());
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
